// File: design/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    // cache geometry
    localparam int ADDR_W   = 32;
    localparam int WORD_W   = 64;
    localparam int BANK_NUM = 8;
    localparam int LINE_W   = BANK_NUM * WORD_W;  // 512 bits
    localparam int BANK_W   = $clog2(BANK_NUM);
    localparam int OFFSET_W = 6;                   // byte offset, bank is its top bits
    localparam int SET_W    = 9;
    localparam int TAG_W    = ADDR_W - SET_W - OFFSET_W;  // addr[31:15]
    localparam int WAY_NUM  = 2;

    localparam logic [7:0] LFSR_SEED = 8'hff;  // any nonzero value

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [WORD_W-1:0] word_t;
    typedef logic [LINE_W-1:0] line_t;

    typedef struct packed {
        logic             valid;
        logic             dirty;
        logic [TAG_W-1:0] tag;
    } tag_entry_t;

    typedef tag_entry_t [WAY_NUM-1:0] tag_set_t;  // way 1 in the upper half

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } op_t;

    function automatic logic [SET_W-1:0] addr_set(input addr_t addr);
        return addr[OFFSET_W +: SET_W];
    endfunction

    function automatic logic [TAG_W-1:0] addr_tag(input addr_t addr);
        return addr[ADDR_W-1 -: TAG_W];
    endfunction

    function automatic logic [BANK_W-1:0] addr_bank(input addr_t addr);
        return addr[OFFSET_W-1 -: BANK_W];
    endfunction

    // aligned line address from tag and set
    function automatic addr_t line_base(input logic [TAG_W-1:0] tag,
                                        input logic [SET_W-1:0] set);
        return {tag, set, {OFFSET_W{1'b0}}};
    endfunction

endpackage

`default_nettype wire

// File: design/set_ram.sv
`default_nettype none

module set_ram #(
    parameter type entry_t = logic [7:0],
    parameter int  DEPTH_W = 9
) (
    input  logic               clock,
    input  logic               reset_n,
    input  logic               enable,
    input  logic               write,
    input  logic [DEPTH_W-1:0] addr,
    input  entry_t             write_data,
    input  entry_t             write_mask,
    output entry_t             read_data
);

    entry_t mem [2**DEPTH_W];

    // bit-masked write, untouched bits keep their old value
    always_ff @(posedge clock) begin
        if (enable && write) begin
            mem[addr] <= entry_t'((mem[addr] & ~write_mask) | (write_data & write_mask));
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            read_data <= '0;
        end else if (enable && !write) begin
            read_data <= mem[addr];  // held until the next read
        end
    end

endmodule

`default_nettype wire

// File: design/request_front.sv
`default_nettype none

module request_front (
    input  logic                clock,
    input  logic                reset_n,
    input  logic                req_valid,
    input  dcache_pkg::addr_t   req_addr,
    input  dcache_pkg::op_t     req_op,
    input  dcache_pkg::word_t   req_write_data,
    input  dcache_pkg::word_t   req_write_mask,
    input  logic                done,
    input  dcache_pkg::line_t   line_in,
    output logic                req_ready,
    output logic                pend_valid,
    output dcache_pkg::addr_t   pend_addr,
    output dcache_pkg::op_t     pend_op,
    output dcache_pkg::line_t   merged_line,
    output dcache_pkg::word_t   selected_word
);

    dcache_pkg::word_t               wdata_q;
    dcache_pkg::word_t               wmask_q;
    logic [dcache_pkg::BANK_W-1:0]   bank;
    logic                            accept;

    assign accept    = req_valid && req_ready;
    assign req_ready = !pend_valid;  // one request in flight
    assign bank      = dcache_pkg::addr_bank(pend_addr);

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            pend_valid <= 1'b0;
        end else if (accept) begin
            pend_valid <= 1'b1;
        end else if (done) begin
            pend_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            pend_addr <= req_addr;
            pend_op   <= req_op;
            wdata_q   <= req_write_data;
            wmask_q   <= req_write_mask;
        end
    end

    // word of the held address, from whichever line the controller routes in
    assign selected_word = line_in[bank*dcache_pkg::WORD_W +: dcache_pkg::WORD_W];

    always_comb begin
        merged_line = line_in;
        merged_line[bank*dcache_pkg::WORD_W +: dcache_pkg::WORD_W] =
            (wdata_q & wmask_q) | (selected_word & ~wmask_q);
    end

endmodule

`default_nettype wire

// File: design/victim_select.sv
`default_nettype none

module victim_select (
    input  logic                  clock,
    input  logic                  reset_n,
    input  dcache_pkg::tag_set_t  tag_set,
    output logic                  victim_way,
    output logic                  victim_dirty
);

    logic [7:0]                        lfsr;
    logic [dcache_pkg::WAY_NUM-1:0]    valid_vec;
    logic [dcache_pkg::WAY_NUM-1:0]    dirty_vec;

    // x^8 + x^6 + x^5 + x^4 + 1, free running
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            lfsr <= dcache_pkg::LFSR_SEED;
        end else begin
            lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
        end
    end

    always_comb begin
        for (int w = 0; w < dcache_pkg::WAY_NUM; w++) begin
            valid_vec[w] = tag_set[w].valid;
            dirty_vec[w] = tag_set[w].dirty;
        end
    end

    // invalid first, then clean, then random
    always_comb begin
        if (!valid_vec[0]) begin
            victim_way = 1'b0;
        end else if (!valid_vec[1]) begin
            victim_way = 1'b1;
        end else if (!dirty_vec[0]) begin
            victim_way = 1'b0;
        end else if (!dirty_vec[1]) begin
            victim_way = 1'b1;
        end else begin
            victim_way = lfsr[0];
        end
    end

    assign victim_dirty = valid_vec[victim_way] && dirty_vec[victim_way];

endmodule

`default_nettype wire

// File: design/cache_controller.sv
`default_nettype none

module cache_controller (
    input  logic                          clock,
    input  logic                          reset_n,
    input  logic                          pend_valid,
    input  dcache_pkg::addr_t             pend_addr,
    input  dcache_pkg::op_t               pend_op,
    input  dcache_pkg::line_t             merged_line,
    input  dcache_pkg::word_t             selected_word,
    input  dcache_pkg::tag_set_t          tag_rd,
    input  dcache_pkg::line_t             line_rd,
    input  logic                          victim_way,
    input  logic                          victim_dirty,
    input  logic                          mem_ready,
    input  dcache_pkg::line_t             mem_read_data,
    input  logic                          mem_done,
    output logic                          done,
    output dcache_pkg::word_t             req_read_data,
    output logic                          tag_en,
    output logic                          tag_we,
    output logic [dcache_pkg::SET_W-1:0]  tag_addr,
    output dcache_pkg::tag_set_t          tag_wr,
    output dcache_pkg::tag_set_t          tag_mask,
    output logic                          line_en,
    output logic                          line_we,
    output logic [dcache_pkg::SET_W:0]    line_addr,
    output dcache_pkg::line_t             line_wr,
    output dcache_pkg::line_t             line_mask,
    output dcache_pkg::line_t             line_to_front,
    output logic                          mem_valid,
    output dcache_pkg::addr_t             mem_addr,
    output dcache_pkg::op_t               mem_op,
    output dcache_pkg::line_t             mem_write_data
);

    typedef enum logic [2:0] {
        IDLE, TAG_READ, LOOKUP, READ_LINE, WRITE_BACK, FETCH, REFILL, RESPOND
    } state_t;

    state_t                            state;
    state_t                            next_state;
    logic [dcache_pkg::SET_W-1:0]      set_idx;
    logic [dcache_pkg::TAG_W-1:0]      req_tag;
    logic [dcache_pkg::BANK_W-1:0]     bank;
    logic                              is_store;
    logic                              hit0;
    logic                              hit1;
    logic                              hit;
    logic                              hit_way;
    logic                              way_q;        // hit way, or victim on a miss
    dcache_pkg::word_t                 resp_word;
    dcache_pkg::line_t                 refill_line;
    logic                              wb_issue;
    logic                              fetch_issue;

    assign set_idx  = dcache_pkg::addr_set(pend_addr);
    assign req_tag  = dcache_pkg::addr_tag(pend_addr);
    assign bank     = dcache_pkg::addr_bank(pend_addr);
    assign is_store = (pend_op == dcache_pkg::OP_WRITE);

    // tag set is on the RAM output from TAG_READ on
    assign hit0    = tag_rd[0].valid && (tag_rd[0].tag == req_tag);
    assign hit1    = tag_rd[1].valid && (tag_rd[1].tag == req_tag);
    assign hit     = hit0 || hit1;
    assign hit_way = !hit0;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE:       if (pend_valid) next_state = TAG_READ;
            TAG_READ: begin
                if (hit) begin
                    next_state = LOOKUP;
                end else if (victim_dirty) begin
                    next_state = READ_LINE;
                end else begin
                    next_state = FETCH;
                end
            end
            LOOKUP:     next_state = is_store ? IDLE : RESPOND;  // store hit ends here
            READ_LINE:  next_state = WRITE_BACK;
            WRITE_BACK: if (mem_done) next_state = FETCH;
            FETCH:      if (mem_done) next_state = REFILL;
            REFILL:     next_state = RESPOND;
            default:    next_state = IDLE;
        endcase
    end

    always_ff @(posedge clock) begin
        if (state == TAG_READ) begin
            way_q <= hit ? hit_way : victim_way;
        end
        if (state == LOOKUP) begin
            resp_word <= selected_word;
        end
        if (state == FETCH && mem_done) begin
            resp_word   <= selected_word;
            refill_line <= is_store ? merged_line : mem_read_data;
        end
    end

    // fetched data goes through the merge unit, otherwise the line RAM does
    assign line_to_front = (state == FETCH) ? mem_read_data : line_rd;

    always_comb begin
        tag_en    = 1'b0;
        tag_we    = 1'b0;
        tag_addr  = set_idx;
        tag_wr    = tag_rd;
        tag_mask  = '0;
        line_en   = 1'b0;
        line_we   = 1'b0;
        line_addr = {set_idx, way_q};
        line_wr   = merged_line;
        line_mask = '0;
        case (state)
            IDLE: tag_en = pend_valid;  // tag read
            TAG_READ: begin
                line_en   = hit || victim_dirty;  // hit line or dirty victim
                line_addr = {set_idx, hit ? hit_way : victim_way};
            end
            LOOKUP: begin
                if (is_store) begin
                    line_en   = 1'b1;
                    line_we   = 1'b1;
                    line_mask[bank*dcache_pkg::WORD_W +: dcache_pkg::WORD_W] = '1;
                    tag_en    = 1'b1;
                    tag_we    = 1'b1;
                    tag_wr[way_q].dirty = 1'b1;
                    tag_mask[way_q]     = '1;
                end
            end
            REFILL: begin
                line_en   = 1'b1;
                line_we   = 1'b1;
                line_wr   = refill_line;
                line_mask = '1;
                tag_en    = 1'b1;
                tag_we    = 1'b1;
                tag_wr[way_q]   = '{valid: 1'b1, dirty: is_store, tag: req_tag};
                tag_mask[way_q] = '1;
            end
            default: begin
            end
        endcase
    end

    assign done          = (state == RESPOND) || (state == LOOKUP && is_store);
    assign req_read_data = (state == RESPOND && !is_store) ? resp_word : '0;

    assign wb_issue    = (state == READ_LINE);
    assign fetch_issue = (state == TAG_READ && !hit && !victim_dirty) ||
                         (state == WRITE_BACK && mem_done);

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            mem_valid <= 1'b0;
        end else if (wb_issue || fetch_issue) begin
            mem_valid <= 1'b1;
        end else if (mem_valid && mem_ready) begin
            mem_valid <= 1'b0;  // accepted
        end
    end

    always_ff @(posedge clock) begin
        if (wb_issue) begin
            mem_addr       <= dcache_pkg::line_base(tag_rd[way_q].tag, set_idx);
            mem_op         <= dcache_pkg::OP_WRITE;
            mem_write_data <= line_rd;
        end else if (fetch_issue) begin
            mem_addr <= dcache_pkg::line_base(req_tag, set_idx);
            mem_op   <= dcache_pkg::OP_READ;
        end
    end

endmodule

`default_nettype wire

// File: design/dcache_top.sv
`default_nettype none

module dcache_top (
    input  logic                clock,
    input  logic                reset_n,
    input  logic                req_valid,
    input  dcache_pkg::addr_t   req_addr,
    input  dcache_pkg::op_t     req_op,
    input  dcache_pkg::word_t   req_write_data,
    input  dcache_pkg::word_t   req_write_mask,
    output logic                req_ready,
    output dcache_pkg::word_t   req_read_data,
    output logic                req_done,
    output logic                mem_valid,
    output dcache_pkg::addr_t   mem_addr,
    output dcache_pkg::op_t     mem_op,
    output dcache_pkg::line_t   mem_write_data,
    input  logic                mem_ready,
    input  dcache_pkg::line_t   mem_read_data,
    input  logic                mem_done
);

    logic                             pend_valid;
    dcache_pkg::addr_t                pend_addr;
    dcache_pkg::op_t                  pend_op;
    dcache_pkg::line_t                merged_line;
    dcache_pkg::word_t                selected_word;
    dcache_pkg::line_t                line_to_front;
    logic                             tag_en;
    logic                             tag_we;
    logic [dcache_pkg::SET_W-1:0]     tag_addr;
    dcache_pkg::tag_set_t             tag_wr;
    dcache_pkg::tag_set_t             tag_mask;
    dcache_pkg::tag_set_t             tag_rd;
    logic                             line_en;
    logic                             line_we;
    logic [dcache_pkg::SET_W:0]       line_addr;  // {set, way}
    dcache_pkg::line_t                line_wr;
    dcache_pkg::line_t                line_mask;
    dcache_pkg::line_t                line_rd;
    logic                             victim_way;
    logic                             victim_dirty;

    request_front front_i (
        .clock          (clock),
        .reset_n        (reset_n),
        .req_valid      (req_valid),
        .req_addr       (req_addr),
        .req_op         (req_op),
        .req_write_data (req_write_data),
        .req_write_mask (req_write_mask),
        .done           (req_done),
        .line_in        (line_to_front),
        .req_ready      (req_ready),
        .pend_valid     (pend_valid),
        .pend_addr      (pend_addr),
        .pend_op        (pend_op),
        .merged_line    (merged_line),
        .selected_word  (selected_word)
    );

    set_ram #(
        .entry_t (dcache_pkg::tag_set_t),
        .DEPTH_W (dcache_pkg::SET_W)
    ) tag_ram_i (
        .clock      (clock),
        .reset_n    (reset_n),
        .enable     (tag_en),
        .write      (tag_we),
        .addr       (tag_addr),
        .write_data (tag_wr),
        .write_mask (tag_mask),
        .read_data  (tag_rd)
    );

    set_ram #(
        .entry_t (dcache_pkg::line_t),
        .DEPTH_W (dcache_pkg::SET_W + 1)
    ) line_ram_i (
        .clock      (clock),
        .reset_n    (reset_n),
        .enable     (line_en),
        .write      (line_we),
        .addr       (line_addr),
        .write_data (line_wr),
        .write_mask (line_mask),
        .read_data  (line_rd)
    );

    victim_select victim_i (
        .clock        (clock),
        .reset_n      (reset_n),
        .tag_set      (tag_rd),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty)
    );

    cache_controller ctrl_i (
        .clock          (clock),
        .reset_n        (reset_n),
        .pend_valid     (pend_valid),
        .pend_addr      (pend_addr),
        .pend_op        (pend_op),
        .merged_line    (merged_line),
        .selected_word  (selected_word),
        .tag_rd         (tag_rd),
        .line_rd        (line_rd),
        .victim_way     (victim_way),
        .victim_dirty   (victim_dirty),
        .mem_ready      (mem_ready),
        .mem_read_data  (mem_read_data),
        .mem_done       (mem_done),
        .done           (req_done),
        .req_read_data  (req_read_data),
        .tag_en         (tag_en),
        .tag_we         (tag_we),
        .tag_addr       (tag_addr),
        .tag_wr         (tag_wr),
        .tag_mask       (tag_mask),
        .line_en        (line_en),
        .line_we        (line_we),
        .line_addr      (line_addr),
        .line_wr        (line_wr),
        .line_mask      (line_mask),
        .line_to_front  (line_to_front),
        .mem_valid      (mem_valid),
        .mem_addr       (mem_addr),
        .mem_op         (mem_op),
        .mem_write_data (mem_write_data)
    );

endmodule

`default_nettype wire

// File: bench/ddr_responder.sv
`default_nettype none

module ddr_responder (
    input  logic               clock,
    input  logic               mem_valid,
    input  dcache_pkg::addr_t  mem_addr,
    input  dcache_pkg::op_t    mem_op,
    input  dcache_pkg::line_t  mem_write_data,
    output logic               mem_ready,
    output dcache_pkg::line_t  mem_read_data,
    output logic               mem_done
);

    dcache_pkg::line_t  lines [dcache_pkg::addr_t];  // only lines that were written back
    int                 seed;
    int                 ready_delay;
    int                 done_delay;
    dcache_pkg::addr_t  addr_q;
    dcache_pkg::op_t    op_q;
    dcache_pkg::line_t  data_q;

    // untouched words hold their own address xor a fixed pattern
    function automatic dcache_pkg::line_t untouched_line(input dcache_pkg::addr_t base);
        dcache_pkg::line_t line;
        dcache_pkg::addr_t word_addr;
        for (int b = 0; b < dcache_pkg::BANK_NUM; b++) begin
            word_addr = base + dcache_pkg::addr_t'(b * 8);
            line[b*dcache_pkg::WORD_W +: dcache_pkg::WORD_W] =
                {32'h0, word_addr} ^ 64'h5a5a_0000_0000_a5a5;
        end
        return line;
    endfunction

    initial begin
        seed          = 32'he781;
        mem_ready     = 1'b0;
        mem_done      = 1'b0;
        mem_read_data = '0;
        forever begin
            @(negedge clock);
            if (mem_valid) begin
                addr_q      = mem_addr;  // fields stay stable until the handshake
                op_q        = mem_op;
                data_q      = mem_write_data;
                ready_delay = {$random(seed)} % 4;
                done_delay  = 1 + {$random(seed)} % 6;
                repeat (ready_delay) @(posedge clock);
                @(posedge clock);
                mem_ready <= 1'b1;
                @(posedge clock);  // handshake edge
                mem_ready <= 1'b0;
                repeat (done_delay - 1) @(posedge clock);
                @(posedge clock);
                if (op_q == dcache_pkg::OP_WRITE) begin
                    lines[addr_q] = data_q;
                end else if (lines.exists(addr_q)) begin
                    mem_read_data <= lines[addr_q];
                end else begin
                    mem_read_data <= untouched_line(addr_q);
                end
                mem_done <= 1'b1;
                @(posedge clock);
                mem_done      <= 1'b0;
                mem_read_data <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: bench/dcache_tb.sv
`default_nettype none

module dcache_tb;

    localparam int RANDOM_OPS      = 600;
    localparam int OP_COUNT        = 7 + RANDOM_OPS;
    localparam int WATCHDOG_CYCLES = 200 * OP_COUNT + 16;

    // more tags than ways in each of the four sets
    localparam logic [16:0] TAG_POOL [5] = '{17'h00001, 17'h0a5a5, 17'h1ffff,
                                             17'h00400, 17'h13579};
    localparam logic [8:0]  SET_POOL [4] = '{9'h003, 9'h0a0, 9'h155, 9'h1fe};

    typedef struct packed {
        dcache_pkg::op_t    op;
        dcache_pkg::addr_t  addr;
        dcache_pkg::word_t  data;
        dcache_pkg::word_t  mask;
    } req_rec_t;

    logic               clock;
    logic               reset_n;
    logic               req_valid;
    dcache_pkg::addr_t  req_addr;
    dcache_pkg::op_t    req_op;
    dcache_pkg::word_t  req_write_data;
    dcache_pkg::word_t  req_write_mask;
    logic               req_ready;
    dcache_pkg::word_t  req_read_data;
    logic               req_done;
    logic               mem_valid;
    dcache_pkg::addr_t  mem_addr;
    dcache_pkg::op_t    mem_op;
    dcache_pkg::line_t  mem_write_data;
    logic               mem_ready;
    dcache_pkg::line_t  mem_read_data;
    logic               mem_done;

    dcache_pkg::word_t  model [dcache_pkg::addr_t];  // last merged store per word
    req_rec_t           pending [$];
    req_rec_t           rec;
    int                 seed;
    int                 done_count;
    int                 tag_idx;
    int                 set_idx;
    int                 bank_idx;
    dcache_pkg::op_t    rand_op;
    dcache_pkg::word_t  rand_data;
    dcache_pkg::word_t  rand_mask;

    dcache_top dut_i (
        .clock          (clock),
        .reset_n        (reset_n),
        .req_valid      (req_valid),
        .req_addr       (req_addr),
        .req_op         (req_op),
        .req_write_data (req_write_data),
        .req_write_mask (req_write_mask),
        .req_ready      (req_ready),
        .req_read_data  (req_read_data),
        .req_done       (req_done),
        .mem_valid      (mem_valid),
        .mem_addr       (mem_addr),
        .mem_op         (mem_op),
        .mem_write_data (mem_write_data),
        .mem_ready      (mem_ready),
        .mem_read_data  (mem_read_data),
        .mem_done       (mem_done)
    );

    ddr_responder mem_i (
        .clock          (clock),
        .mem_valid      (mem_valid),
        .mem_addr       (mem_addr),
        .mem_op         (mem_op),
        .mem_write_data (mem_write_data),
        .mem_ready      (mem_ready),
        .mem_read_data  (mem_read_data),
        .mem_done       (mem_done)
    );

    always #2 clock = ~clock;

    function automatic dcache_pkg::word_t expected_word(input dcache_pkg::addr_t addr);
        dcache_pkg::addr_t key;
        key = {addr[31:3], 3'b000};
        if (model.exists(key)) begin
            return model[key];
        end
        return {32'h0, key} ^ 64'h5a5a_0000_0000_a5a5;  // never stored
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input dcache_pkg::word_t actual,
                               input dcache_pkg::word_t expected);
        if (actual !== expected) begin
            abort_run($sformatf("mismatch %s: got %h, expected %h", name, actual, expected));
        end
    endtask

    // blocks until the request's req_done
    task automatic issue(input dcache_pkg::op_t op_in, input dcache_pkg::addr_t addr_in,
                         input dcache_pkg::word_t data_in, input dcache_pkg::word_t mask_in);
        @(negedge clock);
        while (!req_ready) begin
            @(negedge clock);
        end
        @(posedge clock);
        req_valid      <= 1'b1;
        req_addr       <= addr_in;
        req_op         <= op_in;
        req_write_data <= data_in;
        req_write_mask <= mask_in;
        @(posedge clock);  // accepted on this edge
        req_valid <= 1'b0;
        pending.push_back(req_rec_t'{op: op_in, addr: addr_in, data: data_in, mask: mask_in});
        while (pending.size() != 0) begin
            @(posedge clock);
        end
    endtask

    // response and memory bus checks on the falling edge
    always @(negedge clock) begin
        if (reset_n) begin
            if (req_done) begin
                if (pending.size() == 0) begin
                    abort_run("req_done pulsed with no request outstanding");
                end else begin
                    rec = pending.pop_front();
                    done_count++;
                    if (rec.op == dcache_pkg::OP_READ) begin
                        check_value("req_read_data", req_read_data, expected_word(rec.addr));
                    end else begin
                        check_value("req_read_data", req_read_data, '0);
                        model[{rec.addr[31:3], 3'b000}] = (rec.data & rec.mask) |
                            (expected_word(rec.addr) & ~rec.mask);
                    end
                end
            end else begin
                check_value("req_read_data", req_read_data, '0);
                if (pending.size() != 0) begin
                    check_value("req_ready", {63'd0, req_ready}, 64'd0);  // busy
                end
            end
            if (mem_valid && mem_ready) begin
                check_value("mem_addr[5:0]", {58'd0, mem_addr[5:0]}, 64'd0);
                if (mem_op == dcache_pkg::OP_WRITE) begin
                    for (int b = 0; b < dcache_pkg::BANK_NUM; b++) begin
                        check_value($sformatf("mem_write_data bank %0d", b),
                                    mem_write_data[b*dcache_pkg::WORD_W +: dcache_pkg::WORD_W],
                                    expected_word(mem_addr + dcache_pkg::addr_t'(b * 8)));
                    end
                end else begin
                    // a fetch always targets the line of the request in flight
                    check_value("mem_addr", {32'd0, mem_addr},
                                {32'd0, pending[0].addr[31:6], 6'd0});
                end
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        abort_run($sformatf("timeout after %0d cycles, %0d of %0d requests done",
                            WATCHDOG_CYCLES, done_count, OP_COUNT));
    end

    initial begin
        clock          = 1'b0;
        reset_n        = 1'b0;
        req_valid      = 1'b0;
        req_addr       = '0;
        req_op         = dcache_pkg::OP_READ;
        req_write_data = '0;
        req_write_mask = '0;
        seed           = 32'he781;
        done_count     = 0;
        repeat (16) @(posedge clock);
        reset_n <= 1'b1;
        @(negedge clock);
        check_value("req_ready", {63'd0, req_ready}, 64'd1);
        check_value("req_done", {63'd0, req_done}, 64'd0);
        check_value("mem_valid", {63'd0, mem_valid}, 64'd0);

        issue(dcache_pkg::OP_READ, 32'h1234_5678, '0, '0);  // clean read miss

        // store miss, store hit, then a second line
        issue(dcache_pkg::OP_WRITE, 32'h0040_8010, 64'h0123_4567_89ab_cdef,
              64'h0000_ffff_ffff_0000);
        issue(dcache_pkg::OP_READ, 32'h0040_8010, '0, '0);
        issue(dcache_pkg::OP_WRITE, 32'h0040_8010, 64'hfedc_ba98_7654_3210,
              64'hff00_ff00_ff00_ff00);
        issue(dcache_pkg::OP_READ, 32'h0040_8010, '0, '0);
        issue(dcache_pkg::OP_WRITE, 32'h0c00_1238, 64'h5555_aaaa_3333_cccc, 64'h0f0f_0f0f_0f0f_0f0f);
        issue(dcache_pkg::OP_READ, 32'h0c00_1238, '0, '0);

        for (int i = 0; i < RANDOM_OPS; i++) begin
            tag_idx   = {$random(seed)} % 5;
            set_idx   = {$random(seed)} % 4;
            bank_idx  = {$random(seed)} % 8;
            rand_op   = ({$random(seed)} % 2 == 0) ? dcache_pkg::OP_READ : dcache_pkg::OP_WRITE;
            rand_data = {$random(seed), $random(seed)};
            rand_mask = ({$random(seed)} % 4 == 0) ? '1 : {$random(seed), $random(seed)};
            issue(rand_op, {TAG_POOL[tag_idx], SET_POOL[set_idx], bank_idx[2:0], 3'b000},
                  rand_data, rand_mask);
        end

        repeat (4) @(posedge clock);  // room for a stray req_done
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: dcache.f
design/dcache_pkg.sv
design/set_ram.sv
design/request_front.sv
design/victim_select.sv
design/cache_controller.sv
design/dcache_top.sv
bench/ddr_responder.sv
bench/dcache_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module dcache_tb -f dcache.f -o dcache_sim
./obj_dir/dcache_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Verification failed" sim.log; then
    exit 1
fi
grep -q "Verification passed" sim.log
